// File: hdl/ddr_rd_params.svh
`ifndef DDR_RD_PARAMS_SVH
`define DDR_RD_PARAMS_SVH

////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////

`define DDR_ADDR_W      32      // byte address
`define DDR_DATA_W      64      // one read beat
`define DDR_KEEP_W      8       // byte lanes per beat
`define DDR_LEN_W       9       // beat count 1..256
`define AXI_LEN_W       8       // ARLEN field, beats minus one

////////////////////////////////////////////////////////////
// buffering and burst geometry
////////////////////////////////////////////////////////////

// room for two full bursts
`define BEAT_FIFO_DEPTH 512
`define DESC_FIFO_DEPTH 16      // frames waiting to stream

// address step between consecutive beats
`define BEAT_BYTES      8

`endif

// File: hdl/axi_rd_pkg.sv
`default_nettype none

`include "ddr_rd_params.svh"

package axi_rd_pkg;

    ////////////////////////////////////////////////////////////
    // AXI4 read address channel
    ////////////////////////////////////////////////////////////

    // INCR bursts of full bus width only
    typedef struct packed {
        logic [`DDR_ADDR_W-1:0] addr;   // first beat byte address
        logic [`AXI_LEN_W-1:0]  len;    // beats minus one
    } axi_ar_t;

    ////////////////////////////////////////////////////////////
    // AXI4 read data channel
    ////////////////////////////////////////////////////////////

    // id and resp not carried
    typedef struct packed {
        logic [`DDR_DATA_W-1:0] data;
        logic                   last;   // final beat of burst
    } axi_r_t;

endpackage

`default_nettype wire

// File: hdl/ddr_rd_pkg.sv
`default_nettype none

`include "ddr_rd_params.svh"

package ddr_rd_pkg;

    ////////////////////////////////////////////////////////////
    // requester side
    ////////////////////////////////////////////////////////////

    // one read request maps to one burst and one frame
    typedef struct packed {
        logic [`DDR_ADDR_W-1:0] addr;   // start byte address
        logic [`DDR_LEN_W-1:0]  len;    // beat count 1..256
        logic [`DDR_KEEP_W-1:0] keep;   // byte mask of last beat
    } ddr_rd_req_t;

    ////////////////////////////////////////////////////////////
    // frame descriptor
    ////////////////////////////////////////////////////////////

    // written once a burst has fully landed in the beat FIFO
    typedef struct packed {
        logic [`DDR_LEN_W-1:0]  len;    // beats in frame
        logic [`DDR_KEEP_W-1:0] keep;   // tkeep on tlast beat
    } frame_desc_t;

endpackage

`default_nettype wire

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// first-word-fall-through FIFO with the head always on o_data
module sync_fifo #(
    parameter type T_DATA = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  wire logic  i_axis_clk,
    input  wire logic  i_axis_rst,
    input  wire logic  i_push,
    input  wire T_DATA i_data,
    input  wire logic  i_pop,
    output T_DATA      o_data,
    output logic       o_empty,
    output logic       o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T_DATA            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;           // entries held
    logic             do_push;
    logic             do_pop;

    // wraps at DEPTH so non power of two depths work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = i_push && !o_full;    // push into a full FIFO is lost
    assign do_pop  = i_pop && !o_empty;
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge i_axis_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // neither or both at once
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/axi_rd_issuer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rd_params.svh"

module axi_rd_issuer (
    input  wire logic                      i_axis_clk,
    input  wire logic                      i_axis_rst,

    // requester
    input  wire ddr_rd_pkg::ddr_rd_req_t   i_req,
    input  wire logic                      i_req_valid,
    output logic                           o_req_ready,

    // AR channel
    output axi_rd_pkg::axi_ar_t            o_ar,
    output logic                           o_ar_valid,
    input  wire logic                      i_ar_ready,

    // R channel
    input  wire axi_rd_pkg::axi_r_t        i_r,
    input  wire logic                      i_r_valid,
    output logic                           o_r_ready,

    // beat FIFO write side
    output logic                           o_beat_push,
    output logic [`DDR_DATA_W-1:0]         o_beat_data,
    input  wire logic                      i_beat_full,

    // descriptor FIFO write side
    output logic                           o_desc_push,
    output ddr_rd_pkg::frame_desc_t        o_desc,
    input  wire logic                      i_desc_full
);

    ddr_rd_pkg::ddr_rd_req_t req_q;    // request of the burst in flight
    logic                    busy;     // burst outstanding
    logic                    req_take;
    logic                    r_fire;

    ////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////

    // one burst at a time with a free descriptor slot
    assign o_req_ready = !busy && !i_desc_full;
    assign req_take    = i_req_valid && o_req_ready;

    always_ff @(posedge i_axis_clk) begin
        if (req_take) begin
            req_q <= i_req;
        end
    end

    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            busy <= 1'b0;
        end else if (req_take) begin
            busy <= 1'b1;
        end else if (r_fire && i_r.last) begin
            busy <= 1'b0;    // last beat taken
        end
    end

    ////////////////////////////////////////////////////////////
    // AR channel
    ////////////////////////////////////////////////////////////

    assign o_ar.addr = req_q.addr;
    assign o_ar.len  = `AXI_LEN_W'(req_q.len - `DDR_LEN_W'(1));   // beats minus one

    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            o_ar_valid <= 1'b0;
        end else if (req_take) begin
            o_ar_valid <= 1'b1;
        end else if (i_ar_ready) begin
            o_ar_valid <= 1'b0;    // handshake done
        end
    end

    ////////////////////////////////////////////////////////////
    // R channel
    ////////////////////////////////////////////////////////////

    // stall the slave while the beat FIFO has no room
    assign o_r_ready = busy && !i_beat_full;
    assign r_fire    = i_r_valid && o_r_ready;

    assign o_beat_push = r_fire;
    assign o_beat_data = i_r.data;

    // descriptor goes out with the closing beat
    assign o_desc_push = r_fire && i_r.last;
    assign o_desc.len  = req_q.len;
    assign o_desc.keep = req_q.keep;

endmodule

`default_nettype wire

// File: hdl/axis_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rd_params.svh"

module axis_framer (
    input  wire logic                    i_axis_clk,
    input  wire logic                    i_axis_rst,

    // descriptor FIFO head
    input  wire ddr_rd_pkg::frame_desc_t i_desc,
    input  wire logic                    i_desc_empty,
    output logic                         o_desc_pop,

    // beat FIFO head
    input  wire logic [`DDR_DATA_W-1:0]  i_beat_data,
    input  wire logic                    i_beat_empty,
    output logic                         o_beat_pop,

    // AXIS master
    output logic [`DDR_DATA_W-1:0]       o_axis_tdata,
    output logic [`DDR_KEEP_W-1:0]       o_axis_tkeep,
    output logic                         o_axis_tlast,
    output logic                         o_axis_tvalid,
    input  wire logic                    i_axis_tready
);

    typedef enum logic {
        ST_IDLE,
        ST_STREAM
    } state_t;

    state_t                  state;
    logic                    desc_pop_q;   // one-cycle pop pulse
    ddr_rd_pkg::frame_desc_t desc_q;       // frame being streamed
    logic [`DDR_LEN_W-1:0]   beat_cnt;     // beats sent in frame
    logic                    streaming;
    logic                    last_beat;
    logic                    tx_fire;

    ////////////////////////////////////////////////////////////
    // descriptor fetch
    ////////////////////////////////////////////////////////////

    assign o_desc_pop = desc_pop_q;

    // head is latched on the same edge that pops it
    always_ff @(posedge i_axis_clk) begin
        if (desc_pop_q) begin
            desc_q <= i_desc;
        end
    end

    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            state      <= ST_IDLE;
            desc_pop_q <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            desc_pop_q <= (state == ST_IDLE) && !i_desc_empty && !desc_pop_q;
            if (desc_pop_q) begin
                state    <= ST_STREAM;
                beat_cnt <= '0;
            end else if (tx_fire) begin
                if (last_beat) begin
                    state    <= ST_IDLE;    // frame done
                    beat_cnt <= '0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // AXIS output
    ////////////////////////////////////////////////////////////

    // all beats of the frame are already buffered once its descriptor exists
    assign streaming = (state == ST_STREAM);
    assign last_beat = streaming && (beat_cnt == desc_q.len - `DDR_LEN_W'(1));
    assign tx_fire   = o_axis_tvalid && i_axis_tready;

    assign o_axis_tvalid = streaming && !i_beat_empty;
    assign o_axis_tdata  = i_beat_data;    // FIFO head holds under stall
    assign o_axis_tlast  = last_beat;
    assign o_axis_tkeep  = last_beat ? desc_q.keep : '1;
    assign o_beat_pop    = tx_fire;

endmodule

`default_nettype wire

// File: hdl/axi_ddr_rd_to_axis.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rd_params.svh"

module axi_ddr_rd_to_axis (
    input  wire logic                    i_axis_clk,
    input  wire logic                    i_axis_rst,

    // requester
    input  wire ddr_rd_pkg::ddr_rd_req_t i_req,
    input  wire logic                    i_req_valid,
    output logic                         o_req_ready,

    // AXI4 read master
    output axi_rd_pkg::axi_ar_t          o_ar,
    output logic                         o_ar_valid,
    input  wire logic                    i_ar_ready,
    input  wire axi_rd_pkg::axi_r_t      i_r,
    input  wire logic                    i_r_valid,
    output logic                         o_r_ready,

    // AXIS master
    output logic [`DDR_DATA_W-1:0]       o_axis_tdata,
    output logic [`DDR_KEEP_W-1:0]       o_axis_tkeep,
    output logic                         o_axis_tlast,
    output logic                         o_axis_tvalid,
    input  wire logic                    i_axis_tready
);

    // beat path
    logic                    beat_push;
    logic [`DDR_DATA_W-1:0]  beat_wdata;
    logic                    beat_full;
    logic                    beat_pop;
    logic [`DDR_DATA_W-1:0]  beat_head;
    logic                    beat_empty;

    // descriptor path
    logic                    desc_push;
    ddr_rd_pkg::frame_desc_t desc_wdata;
    logic                    desc_full;
    logic                    desc_pop;
    ddr_rd_pkg::frame_desc_t desc_head;
    logic                    desc_empty;

    ////////////////////////////////////////////////////////////
    // AXI side
    ////////////////////////////////////////////////////////////

    axi_rd_issuer u_issuer (
        .i_axis_clk  (i_axis_clk),
        .i_axis_rst  (i_axis_rst),
        .i_req       (i_req),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .o_ar        (o_ar),
        .o_ar_valid  (o_ar_valid),
        .i_ar_ready  (i_ar_ready),
        .i_r         (i_r),
        .i_r_valid   (i_r_valid),
        .o_r_ready   (o_r_ready),
        .o_beat_push (beat_push),
        .o_beat_data (beat_wdata),
        .i_beat_full (beat_full),
        .o_desc_push (desc_push),
        .o_desc      (desc_wdata),
        .i_desc_full (desc_full)
    );

    ////////////////////////////////////////////////////////////
    // buffering
    ////////////////////////////////////////////////////////////

    sync_fifo #(
        .T_DATA (logic [`DDR_DATA_W-1:0]),
        .DEPTH  (`BEAT_FIFO_DEPTH)
    ) u_beat_fifo (
        .i_axis_clk (i_axis_clk),
        .i_axis_rst (i_axis_rst),
        .i_push     (beat_push),
        .i_data     (beat_wdata),
        .i_pop      (beat_pop),
        .o_data     (beat_head),
        .o_empty    (beat_empty),
        .o_full     (beat_full)
    );

    sync_fifo #(
        .T_DATA (ddr_rd_pkg::frame_desc_t),
        .DEPTH  (`DESC_FIFO_DEPTH)
    ) u_desc_fifo (
        .i_axis_clk (i_axis_clk),
        .i_axis_rst (i_axis_rst),
        .i_push     (desc_push),
        .i_data     (desc_wdata),
        .i_pop      (desc_pop),
        .o_data     (desc_head),
        .o_empty    (desc_empty),
        .o_full     (desc_full)
    );

    ////////////////////////////////////////////////////////////
    // AXIS side
    ////////////////////////////////////////////////////////////

    axis_framer u_framer (
        .i_axis_clk    (i_axis_clk),
        .i_axis_rst    (i_axis_rst),
        .i_desc        (desc_head),
        .i_desc_empty  (desc_empty),
        .o_desc_pop    (desc_pop),
        .i_beat_data   (beat_head),
        .i_beat_empty  (beat_empty),
        .o_beat_pop    (beat_pop),
        .o_axis_tdata  (o_axis_tdata),
        .o_axis_tkeep  (o_axis_tkeep),
        .o_axis_tlast  (o_axis_tlast),
        .o_axis_tvalid (o_axis_tvalid),
        .i_axis_tready (i_axis_tready)
    );

endmodule

`default_nettype wire

// File: bench/ddr_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rd_params.svh"

// AXI4 read slave serving one burst at a time with address-derived data
module ddr_slave_model #(
    parameter logic [31:0] SEED = 32'h2a49121d
) (
    input  wire logic                i_axis_clk,
    input  wire logic                i_axis_rst,
    input  wire axi_rd_pkg::axi_ar_t i_ar,
    input  wire logic                i_ar_valid,
    output logic                     o_ar_ready,
    output axi_rd_pkg::axi_r_t       o_r,
    output logic                     o_r_valid,
    input  wire logic                i_r_ready
);

    logic [31:0]            lfsr;         // gap source
    logic                   busy;         // burst being served
    logic [`DDR_ADDR_W-1:0] beat_addr;
    logic [`AXI_LEN_W-1:0]  beats_left;   // beats after the current one

    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    assign o_r.data = {beat_addr, beat_addr ^ 32'h5a5a5a5a};
    assign o_r.last = (beats_left == '0);

    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            lfsr       <= SEED;
            busy       <= 1'b0;
            o_ar_ready <= 1'b0;
            o_r_valid  <= 1'b0;
            beat_addr  <= '0;
            beats_left <= '0;
        end else begin
            if (!busy) begin
                o_ar_ready <= 1'b1;
                if (i_ar_valid && o_ar_ready) begin
                    busy       <= 1'b1;
                    o_ar_ready <= 1'b0;
                    beat_addr  <= i_ar.addr;
                    beats_left <= i_ar.len;
                end
            end else if (o_r_valid && i_r_ready) begin
                if (o_r.last) begin
                    busy      <= 1'b0;
                    o_r_valid <= 1'b0;
                end else begin
                    beat_addr  <= beat_addr + `DDR_ADDR_W'(`BEAT_BYTES);
                    beats_left <= beats_left - 1'b1;
                    o_r_valid  <= !lfsr[0];
                    lfsr       <= step_lfsr(lfsr);    // one step per bit taken
                end
            end else if (!o_r_valid) begin
                o_r_valid <= !lfsr[0];    // random gap before a beat
                lfsr      <= step_lfsr(lfsr);
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_axi_ddr_rd_to_axis.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rd_params.svh"

module tb_axi_ddr_rd_to_axis;

    localparam int          NUM_REQS   = 40;
    localparam int          WAIT_LIMIT = 100000;    // cycles per wait loop
    localparam logic [31:0] SEED       = 32'h2a49121d;

    logic                    axis_clk;
    logic                    axis_rst;
    ddr_rd_pkg::ddr_rd_req_t req;
    logic                    req_valid;
    logic                    req_ready;
    axi_rd_pkg::axi_ar_t     ar;
    logic                    ar_valid;
    logic                    ar_ready;
    axi_rd_pkg::axi_r_t      r;
    logic                    r_valid;
    logic                    r_ready;
    logic [`DDR_DATA_W-1:0]  axis_tdata;
    logic [`DDR_KEEP_W-1:0]  axis_tkeep;
    logic                    axis_tlast;
    logic                    axis_tvalid;
    logic                    axis_tready = 1'b0;

    logic [31:0]             lfsr_stim;
    logic [31:0]             lfsr_ready = SEED;    // separate stream for tready
    logic [31:0]             ready_bits;
    ddr_rd_pkg::ddr_rd_req_t exp_q[$];             // scoreboard in request order
    ddr_rd_pkg::ddr_rd_req_t rq;
    int                      beat_idx;
    int                      frames_done;
    logic                    burst_open;
    logic                    prev_stall;
    logic [`DDR_DATA_W-1:0]  prev_data;
    logic [`DDR_KEEP_W-1:0]  prev_keep;
    logic                    prev_last;

    axi_ddr_rd_to_axis i_dut (
        .i_axis_clk    (axis_clk),
        .i_axis_rst    (axis_rst),
        .i_req         (req),
        .i_req_valid   (req_valid),
        .o_req_ready   (req_ready),
        .o_ar          (ar),
        .o_ar_valid    (ar_valid),
        .i_ar_ready    (ar_ready),
        .i_r           (r),
        .i_r_valid     (r_valid),
        .o_r_ready     (r_ready),
        .o_axis_tdata  (axis_tdata),
        .o_axis_tkeep  (axis_tkeep),
        .o_axis_tlast  (axis_tlast),
        .o_axis_tvalid (axis_tvalid),
        .i_axis_tready (axis_tready)
    );

    ddr_slave_model #(.SEED(SEED)) u_slave (
        .i_axis_clk (axis_clk),
        .i_axis_rst (axis_rst),
        .i_ar       (ar),
        .i_ar_valid (ar_valid),
        .o_ar_ready (ar_ready),
        .o_r        (r),
        .o_r_valid  (r_valid),
        .i_r_ready  (r_ready)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one step per bit taken
    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = state[0];
            state   = step_lfsr(state);
        end
    endtask

    // word the slave returns for beat idx of a burst
    function automatic logic [`DDR_DATA_W-1:0] expected_word(input logic [31:0] base,
                                                             input int idx);
        logic [`DDR_ADDR_W-1:0] a;
        a = base + `DDR_ADDR_W'(idx * `BEAT_BYTES);
        return {a, a ^ 32'h5a5a5a5a};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        abort_run("value mismatch");
    endtask

    task automatic check_quiet_outputs();
        assert (!ar_valid) else report_mismatch("o_ar_valid", 64'(ar_valid), 64'h0);
        assert (!r_ready) else report_mismatch("o_r_ready", 64'(r_ready), 64'h0);
        assert (!axis_tvalid) else report_mismatch("o_axis_tvalid", 64'(axis_tvalid), 64'h0);
    endtask

    task automatic wait_req_ready();
        int cycles;
        cycles = 0;
        @(negedge axis_clk);
        while (!req_ready) begin
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("timeout waiting for o_req_ready");
            @(negedge axis_clk);
        end
    endtask

    task automatic issue_request(input ddr_rd_pkg::ddr_rd_req_t q);
        wait_req_ready();
        @(posedge axis_clk);
        req       <= q;
        req_valid <= 1'b1;
        @(negedge axis_clk);
        assert (req_ready) else abort_run("o_req_ready dropped before the strobe");
        assert (!ar_valid) else abort_run("o_ar_valid high before the request was taken");
        @(posedge axis_clk);
        req_valid <= 1'b0;
        @(negedge axis_clk);
        assert (ar_valid) else abort_run("o_ar_valid not raised one cycle after the request");
        assert (ar.addr == q.addr) else report_mismatch("o_ar.addr", 64'(ar.addr), 64'(q.addr));
        assert (ar.len == `AXI_LEN_W'(q.len - 1'b1))
            else report_mismatch("o_ar.len", 64'(ar.len), 64'(q.len - 1'b1));
        exp_q.push_back(q);
    endtask

    task automatic random_request(output ddr_rd_pkg::ddr_rd_req_t q);
        logic [31:0] bits;
        draw_bits(lfsr_stim, 8, bits);
        q.len = `DDR_LEN_W'(bits[7:0]) + 1'b1;    // 1..256
        draw_bits(lfsr_stim, 8, bits);
        q.keep = (bits[7:0] == 8'h00) ? 8'h01 : bits[7:0];
        draw_bits(lfsr_stim, 20, bits);
        q.addr = {9'h0, bits[19:0], 3'b000};    // beat aligned
    endtask

    task automatic check_beat();
        ddr_rd_pkg::ddr_rd_req_t q;
        logic                    is_last;
        logic [`DDR_KEEP_W-1:0]  exp_keep;
        logic [`DDR_DATA_W-1:0]  exp_data;
        if (exp_q.size() == 0) begin
            abort_run("AXIS beat with no request outstanding");
        end else begin
            q        = exp_q[0];
            is_last  = (beat_idx == int'(q.len) - 1);
            exp_keep = is_last ? q.keep : '1;
            exp_data = expected_word(q.addr, beat_idx);
            assert (axis_tdata == exp_data)
                else report_mismatch("o_axis_tdata", axis_tdata, exp_data);
            assert (axis_tlast == is_last)
                else report_mismatch("o_axis_tlast", 64'(axis_tlast), 64'(is_last));
            assert (axis_tkeep == exp_keep)
                else report_mismatch("o_axis_tkeep", 64'(axis_tkeep), 64'(exp_keep));
            if (is_last) begin
                void'(exp_q.pop_front());
                beat_idx = 0;
                frames_done++;
            end else begin
                beat_idx++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // clock, tready and monitor
    ////////////////////////////////////////////////////////////

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    // ready one cycle in four for heavy stalls
    always @(posedge axis_clk) begin
        draw_bits(lfsr_ready, 2, ready_bits);
        axis_tready <= (ready_bits[1:0] == 2'b00);
    end

    always @(negedge axis_clk) begin
        if (!axis_rst) begin
            if (prev_stall) begin    // stalled beat must hold
                assert (axis_tvalid) else abort_run("o_axis_tvalid dropped under a stall");
                assert (axis_tdata == prev_data)
                    else report_mismatch("o_axis_tdata", axis_tdata, prev_data);
                assert (axis_tkeep == prev_keep)
                    else report_mismatch("o_axis_tkeep", 64'(axis_tkeep), 64'(prev_keep));
                assert (axis_tlast == prev_last)
                    else report_mismatch("o_axis_tlast", 64'(axis_tlast), 64'(prev_last));
            end
            if (axis_tvalid && axis_tready) check_beat();
            assert (!(burst_open && req_ready))
                else abort_run("o_req_ready high while a burst is outstanding");
            if (req_valid && req_ready) burst_open = 1'b1;
            if (r_valid && r_ready && r.last) burst_open = 1'b0;
            prev_stall = axis_tvalid && !axis_tready;
            prev_data  = axis_tdata;
            prev_keep  = axis_tkeep;
            prev_last  = axis_tlast;
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int cycles;
        axis_rst    = 1'b1;
        req         = '0;
        req_valid   = 1'b0;
        lfsr_stim   = SEED;
        beat_idx    = 0;
        frames_done = 0;
        burst_open  = 1'b0;
        prev_stall  = 1'b0;
        @(posedge axis_clk);
        @(negedge axis_clk);
        check_quiet_outputs();
        @(posedge axis_clk);
        axis_rst <= 1'b0;    // two edges under reset
        @(negedge axis_clk);
        check_quiet_outputs();
        assert (req_ready) else report_mismatch("o_req_ready", 64'(req_ready), 64'h1);

        // one-beat frame and a full 256-beat burst first
        rq.addr = 32'h0000_1000;
        rq.len  = 9'd1;
        rq.keep = 8'h01;
        issue_request(rq);
        rq.addr = 32'h0002_0000;
        rq.len  = 9'd256;
        rq.keep = 8'h80;
        issue_request(rq);
        for (int i = 2; i < NUM_REQS; i++) begin
            random_request(rq);
            issue_request(rq);
        end

        cycles = 0;
        while (frames_done < NUM_REQS) begin
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("timeout waiting for the last frame");
            @(posedge axis_clk);
        end
        // engine back to idle once the last frame has left
        @(negedge axis_clk);
        if (!axis_tvalid && !ar_valid && !r_ready && req_ready) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("DUT not idle after the last frame");
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/axi_rd_pkg.sv
hdl/ddr_rd_pkg.sv
hdl/sync_fifo.sv
hdl/axi_rd_issuer.sv
hdl/axis_framer.sv
hdl/axi_ddr_rd_to_axis.sv
bench/ddr_slave_model.sv
bench/tb_axi_ddr_rd_to_axis.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

TOP=tb_axi_ddr_rd_to_axis
LOG=sim.log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
        --top-module "$TOP" -f src.f -o "V$TOP"; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished without failure"
exit 0
